// File: hdl/txq_pkg.sv
`default_nettype none

package txq_pkg;

    // ----------------------------------------------------------------------
    // Geometry
    // ----------------------------------------------------------------------
    localparam int ANT_NUM     = 8;
    localparam int LANE_NUM    = 4;
    localparam int GRP_NUM     = 2;
    localparam int SAMPLE_W    = 32;
    localparam int RE_PER_PRB  = 12;
    localparam int PRB_PER_PKT = 4;
    localparam int SLOT_NUM    = 2;

    // ----------------------------------------------------------------------
    // Types
    // ----------------------------------------------------------------------
    // One lane group, lane 0 in the low word
    typedef logic [LANE_NUM-1:0][SAMPLE_W-1:0] lane_data_t;

    // Symbol metadata kept with every sample
    typedef struct packed {
        logic       cell_idx;
        logic [6:0] slot_idx;
        logic [3:0] symb_idx;
    } meta_t;

    typedef enum logic [1:0] {
        SEQ_IDLE,
        SEQ_GRP0,
        SEQ_GRP1
    } seq_state_t;

endpackage

`default_nettype wire

// File: hdl/txq_rd_if.sv
`default_nettype none

interface txq_rd_if #(
    parameter int BLOCK_LEN = 1584
);
    localparam int AW = $clog2(BLOCK_LEN);

    // Read request from the sequencer
    logic                rd_en;
    logic                rd_grp;
    logic                rd_slot;
    logic [AW-1:0]       rd_addr;

    // Read data, one entry per antenna group
    txq_pkg::lane_data_t rd_data [txq_pkg::GRP_NUM];
    txq_pkg::meta_t      rd_meta [txq_pkg::GRP_NUM];
    logic                rd_vld  [txq_pkg::GRP_NUM];

    modport seq (output rd_en, rd_grp, rd_slot, rd_addr);
    modport ram (input rd_en, rd_grp, rd_slot, rd_addr, output rd_data, rd_meta, rd_vld);
    modport out (input rd_grp, rd_data, rd_meta, rd_vld);

endinterface

`default_nettype wire

// File: hdl/txq_write_ctrl.sv
`default_nettype none

module txq_write_ctrl #(
    parameter int BLOCK_LEN = 1584
) (
    input  logic                                                i_clk,
    input  logic                                                i_reset,
    input  logic                                                i_rx_vld,
    input  logic [txq_pkg::ANT_NUM-1:0][txq_pkg::SAMPLE_W-1:0] i_ant_data,
    input  txq_pkg::meta_t                                      i_meta,
    output logic                                                o_wen,
    output logic                                                o_wslot,
    output logic [$clog2(BLOCK_LEN)-1:0]                        o_waddr,
    output txq_pkg::lane_data_t                                 o_wdata_even,
    output txq_pkg::lane_data_t                                 o_wdata_odd,
    output txq_pkg::meta_t                                      o_wmeta,
    output logic                                                o_blk_start,
    output logic                                                o_blk_done
);
    localparam int            AW        = $clog2(BLOCK_LEN);
    localparam logic [AW-1:0] LAST_ADDR = AW'(BLOCK_LEN - 1);

    logic addr_last;

    assign addr_last = (o_waddr == LAST_ADDR);

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            o_wen <= 1'b0;
        end else begin
            o_wen <= i_rx_vld;
        end
    end

    // Even antennas to one group, odd antennas to the other
    always_ff @(posedge i_clk) begin
        for (int k = 0; k < txq_pkg::LANE_NUM; k++) begin
            o_wdata_even[k] <= i_ant_data[2*k];
            o_wdata_odd[k]  <= i_ant_data[2*k+1];
        end
        o_wmeta <= i_meta;
    end

    // Address follows the registered write, slot flips after each block
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            o_waddr <= '0;
            o_wslot <= 1'b0;
        end else if (o_wen) begin
            if (addr_last) begin
                o_waddr <= '0;
                o_wslot <= ~o_wslot;
            end else begin
                o_waddr <= o_waddr + 1'b1;
            end
        end
    end

    assign o_blk_start = o_wen && (o_waddr == '0);
    assign o_blk_done  = o_wen && addr_last;

endmodule

`default_nettype wire

// File: hdl/txq_group_ram.sv
`default_nettype none

module txq_group_ram #(
    parameter int BLOCK_LEN = 1584,
    parameter int GRP       = 0
) (
    input  logic                         i_clk,
    input  logic                         i_wen,
    input  logic                         i_wslot,
    input  logic [$clog2(BLOCK_LEN)-1:0] i_waddr,
    input  txq_pkg::lane_data_t          i_wdata,
    input  txq_pkg::meta_t               i_wmeta,
    txq_rd_if.ram                        rd
);
    // Two block slots, used ping-pong
    txq_pkg::lane_data_t mem_data [txq_pkg::SLOT_NUM][BLOCK_LEN];
    txq_pkg::meta_t      mem_meta [txq_pkg::SLOT_NUM][BLOCK_LEN];

    txq_pkg::lane_data_t data_q;
    txq_pkg::meta_t      meta_q;
    logic                vld_q;

    always_ff @(posedge i_clk) begin
        if (i_wen) begin
            mem_data[i_wslot][i_waddr] <= i_wdata;
            mem_meta[i_wslot][i_waddr] <= i_wmeta;
        end
    end

    // One-cycle registered read
    always_ff @(posedge i_clk) begin
        if (rd.rd_en) begin
            data_q <= mem_data[rd.rd_slot][rd.rd_addr];
            meta_q <= mem_meta[rd.rd_slot][rd.rd_addr];
        end
        vld_q <= rd.rd_en && (rd.rd_grp == 1'(GRP));
    end

    assign rd.rd_data[GRP] = data_q;
    assign rd.rd_meta[GRP] = meta_q;
    assign rd.rd_vld[GRP]  = vld_q;

endmodule

`default_nettype wire

// File: hdl/txq_read_seq.sv
`default_nettype none

module txq_read_seq #(
    parameter int BLOCK_LEN = 1584
) (
    input  logic  i_clk,
    input  logic  i_reset,
    input  logic  i_blk_start,
    input  logic  i_blk_done,
    output logic  o_tready,
    txq_rd_if.seq rd
);
    localparam int            AW        = $clog2(BLOCK_LEN);
    localparam logic [AW-1:0] LAST_ADDR = AW'(BLOCK_LEN - 1);
    localparam logic [1:0]    SLOTS     = 2'(txq_pkg::SLOT_NUM);

    txq_pkg::seq_state_t state;
    logic [1:0]          held_cnt;
    logic [1:0]          ready_cnt;
    logic [AW-1:0]       raddr;
    logic                rslot;
    logic                addr_last;
    logic                release_blk;

    assign addr_last   = (raddr == LAST_ADDR);
    assign release_blk = (state == txq_pkg::SEQ_GRP1) && addr_last;

    // ----------------------------------------------------------------------
    // Block accounting
    // ----------------------------------------------------------------------
    // Held from first write until the last group-1 read
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            held_cnt <= '0;
        end else if (i_blk_start && !release_blk) begin
            held_cnt <= held_cnt + 1'b1;
        end else if (!i_blk_start && release_blk) begin
            held_cnt <= held_cnt - 1'b1;
        end
    end

    // Fully written and waiting for replay
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            ready_cnt <= '0;
        end else if (i_blk_done && !release_blk) begin
            ready_cnt <= ready_cnt + 1'b1;
        end else if (!i_blk_done && release_blk) begin
            ready_cnt <= ready_cnt - 1'b1;
        end
    end

    assign o_tready = (held_cnt < SLOTS);

    // ----------------------------------------------------------------------
    // Replay FSM
    // ----------------------------------------------------------------------
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            state <= txq_pkg::SEQ_IDLE;
            raddr <= '0;
            rslot <= 1'b0;
        end else begin
            case (state)
                txq_pkg::SEQ_IDLE: begin
                    if (ready_cnt != '0) state <= txq_pkg::SEQ_GRP0;
                end
                txq_pkg::SEQ_GRP0: begin
                    if (addr_last) state <= txq_pkg::SEQ_GRP1;
                end
                txq_pkg::SEQ_GRP1: begin
                    if (addr_last) begin
                        rslot <= ~rslot;
                        // Next block already waiting, no idle cycle
                        state <= (ready_cnt > 2'd1) ? txq_pkg::SEQ_GRP0 : txq_pkg::SEQ_IDLE;
                    end
                end
                default: state <= txq_pkg::SEQ_IDLE;
            endcase
            if (state != txq_pkg::SEQ_IDLE) begin
                raddr <= addr_last ? '0 : raddr + 1'b1;
            end
        end
    end

    assign rd.rd_en   = (state != txq_pkg::SEQ_IDLE);
    assign rd.rd_grp  = (state == txq_pkg::SEQ_GRP1);
    assign rd.rd_slot = rslot;
    assign rd.rd_addr = raddr;

    // Upstream must not start a block once both slots are taken
    held_limit_a: assert property (@(posedge i_clk) disable iff (i_reset)
        (held_cnt == SLOTS) |=> (held_cnt <= SLOTS));

endmodule

`default_nettype wire

// File: hdl/txq_re_framer.sv
`default_nettype none

module txq_re_framer #(
    parameter int BLOCK_LEN = 1584
) (
    input  logic       i_clk,
    input  logic       i_reset,
    input  logic       i_vld,
    output logic       o_sop,
    output logic       o_eop,
    output logic [8:0] o_prb_idx
);
    localparam int         PRB_NUM  = BLOCK_LEN / txq_pkg::RE_PER_PRB;
    localparam logic [3:0] RE_LAST  = 4'(txq_pkg::RE_PER_PRB - 1);
    localparam logic [1:0] RB_LAST  = 2'(txq_pkg::PRB_PER_PKT - 1);
    localparam logic [8:0] PRB_LAST = 9'(PRB_NUM - 1);

    logic [3:0] re_cnt;
    logic [1:0] rb_cnt;

    // Element within the resource block
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            re_cnt <= '0;
        end else if (i_vld) begin
            re_cnt <= (re_cnt == RE_LAST) ? '0 : re_cnt + 1'b1;
        end
    end

    // Resource block within the packet, and PRB within the group block
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            rb_cnt    <= '0;
            o_prb_idx <= '0;
        end else if (o_eop) begin
            rb_cnt    <= (rb_cnt == RB_LAST) ? '0 : rb_cnt + 1'b1;
            o_prb_idx <= (o_prb_idx == PRB_LAST) ? '0 : o_prb_idx + 1'b1;
        end
    end

    assign o_eop = i_vld && (re_cnt == RE_LAST);
    assign o_sop = i_vld && (re_cnt == '0) && (rb_cnt == '0);

    // A packet start falls on a PRB index that opens a packet
    sop_prb_a: assert property (@(posedge i_clk) disable iff (i_reset)
        o_sop |-> ((o_prb_idx % txq_pkg::PRB_PER_PKT) == 0));

endmodule

`default_nettype wire

// File: hdl/txq_out_stage.sv
`default_nettype none

module txq_out_stage (
    input  logic                                  i_clk,
    input  logic                                  i_reset,
    input  logic [3:0]                            i_ant0_idx,
    txq_rd_if.out                                 rd,
    output txq_pkg::lane_data_t                   o_tx_data,
    output logic                                  o_tx_vld,
    output txq_pkg::meta_t                        o_meta,
    output logic [txq_pkg::LANE_NUM-1:0][7:0]     o_pkg_info
);
    logic                grp_d;
    logic                sel_vld;
    txq_pkg::lane_data_t sel_data;
    txq_pkg::meta_t      sel_meta;

    // Group of the sample now leaving the memories
    always_ff @(posedge i_clk) begin
        grp_d <= rd.rd_grp;
    end

    always_comb begin
        sel_data = rd.rd_data[grp_d];
        sel_meta = rd.rd_meta[grp_d];
        sel_vld  = rd.rd_vld[0] | rd.rd_vld[1];
    end

    // ----------------------------------------------------------------------
    // Output registers
    // ----------------------------------------------------------------------
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            o_tx_vld <= 1'b0;
        end else begin
            o_tx_vld <= sel_vld;
        end
    end

    // Lane k carries antenna ant0 + 2k + group
    always_ff @(posedge i_clk) begin
        o_tx_data <= sel_data;
        o_meta    <= sel_meta;
        for (int k = 0; k < txq_pkg::LANE_NUM; k++) begin
            o_pkg_info[k] <= {3'b000, grp_d, i_ant0_idx + 4'(2 * k) + {3'b000, grp_d}};
        end
    end

endmodule

`default_nettype wire

// File: hdl/txdata_queue.sv
`default_nettype none

module txdata_queue #(
    parameter int BLOCK_LEN = 1584
) (
    input  logic                                                i_clk,
    input  logic                                                i_reset,
    input  logic [txq_pkg::ANT_NUM-1:0][txq_pkg::SAMPLE_W-1:0] i_ant_data,
    input  logic                                                i_rx_vld,
    input  logic [3:0]                                          i_ant0_idx,
    input  logic                                                i_cell_idx,
    input  logic [6:0]                                          i_slot_idx,
    input  logic [3:0]                                          i_symb_idx,
    output logic [txq_pkg::LANE_NUM-1:0][txq_pkg::SAMPLE_W-1:0] o_tx_data,
    output logic                                                o_tx_vld,
    output logic                                                o_tx_sop,
    output logic                                                o_tx_eop,
    output logic [8:0]                                          o_prb_idx,
    output logic [txq_pkg::LANE_NUM-1:0][7:0]                   o_pkg_info,
    output logic                                                o_cell_idx,
    output logic [6:0]                                          o_slot_idx,
    output logic [3:0]                                          o_symb_idx,
    output logic                                                o_tready
);
    localparam int AW = $clog2(BLOCK_LEN);

    txq_pkg::meta_t      in_meta;
    txq_pkg::meta_t      out_meta;
    txq_pkg::meta_t      wmeta;
    txq_pkg::lane_data_t wdata_even;
    txq_pkg::lane_data_t wdata_odd;
    logic                wen;
    logic                wslot;
    logic [AW-1:0]       waddr;
    logic                blk_start;
    logic                blk_done;

    assign in_meta = '{cell_idx: i_cell_idx, slot_idx: i_slot_idx, symb_idx: i_symb_idx};

    txq_rd_if #(.BLOCK_LEN(BLOCK_LEN)) rd_bus ();

    txq_write_ctrl #(.BLOCK_LEN(BLOCK_LEN)) write_ctrl_i (
        .i_clk        (i_clk),
        .i_reset      (i_reset),
        .i_rx_vld     (i_rx_vld),
        .i_ant_data   (i_ant_data),
        .i_meta       (in_meta),
        .o_wen        (wen),
        .o_wslot      (wslot),
        .o_waddr      (waddr),
        .o_wdata_even (wdata_even),
        .o_wdata_odd  (wdata_odd),
        .o_wmeta      (wmeta),
        .o_blk_start  (blk_start),
        .o_blk_done   (blk_done)
    );

    // Group 0 holds the even antennas, group 1 the odd ones
    txq_group_ram #(.BLOCK_LEN(BLOCK_LEN), .GRP(0)) ram_even_i (
        .i_clk   (i_clk),
        .i_wen   (wen),
        .i_wslot (wslot),
        .i_waddr (waddr),
        .i_wdata (wdata_even),
        .i_wmeta (wmeta),
        .rd      (rd_bus.ram)
    );

    txq_group_ram #(.BLOCK_LEN(BLOCK_LEN), .GRP(1)) ram_odd_i (
        .i_clk   (i_clk),
        .i_wen   (wen),
        .i_wslot (wslot),
        .i_waddr (waddr),
        .i_wdata (wdata_odd),
        .i_wmeta (wmeta),
        .rd      (rd_bus.ram)
    );

    txq_read_seq #(.BLOCK_LEN(BLOCK_LEN)) read_seq_i (
        .i_clk       (i_clk),
        .i_reset     (i_reset),
        .i_blk_start (blk_start),
        .i_blk_done  (blk_done),
        .o_tready    (o_tready),
        .rd          (rd_bus.seq)
    );

    txq_out_stage out_stage_i (
        .i_clk      (i_clk),
        .i_reset    (i_reset),
        .i_ant0_idx (i_ant0_idx),
        .rd         (rd_bus.out),
        .o_tx_data  (o_tx_data),
        .o_tx_vld   (o_tx_vld),
        .o_meta     (out_meta),
        .o_pkg_info (o_pkg_info)
    );

    // Framing runs on the registered output valid
    txq_re_framer #(.BLOCK_LEN(BLOCK_LEN)) re_framer_i (
        .i_clk     (i_clk),
        .i_reset   (i_reset),
        .i_vld     (o_tx_vld),
        .o_sop     (o_tx_sop),
        .o_eop     (o_tx_eop),
        .o_prb_idx (o_prb_idx)
    );

    assign o_cell_idx = out_meta.cell_idx;
    assign o_slot_idx = out_meta.slot_idx;
    assign o_symb_idx = out_meta.symb_idx;

endmodule

`default_nettype wire

// File: bench/txdata_queue_tb.sv
`default_nettype none

module txdata_queue_tb;

    localparam int BLOCK_LEN  = 96;
    localparam int NUM_BLK    = 6;
    localparam int RE_PER_PRB = 12;
    localparam int PKT_LEN    = 48;
    localparam int RESET_CYC  = 16;
    // Three times the replay length of every block, plus reset and drain margin
    localparam int TIMEOUT    = RESET_CYC + NUM_BLK * 3 * 2 * BLOCK_LEN + 200;

    logic             i_clk;
    logic             i_reset;
    logic [7:0][31:0] i_ant_data;
    logic             i_rx_vld;
    logic [3:0]       i_ant0_idx;
    logic             i_cell_idx;
    logic [6:0]       i_slot_idx;
    logic [3:0]       i_symb_idx;
    logic [3:0][31:0] o_tx_data;
    logic             o_tx_vld;
    logic             o_tx_sop;
    logic             o_tx_eop;
    logic [8:0]       o_prb_idx;
    logic [3:0][7:0]  o_pkg_info;
    logic             o_cell_idx;
    logic [6:0]       o_slot_idx;
    logic [3:0]       o_symb_idx;
    logic             o_tready;

    // Expected sample layout: {group, cell, slot, symbol, lane data}
    logic [140:0] exp_q [$];
    logic [140:0] cur_exp;
    int           seed = 70727;
    int           err_cnt = 0;
    int           chk_cnt = 0;
    int           test_pass = 0;
    int           test_fail = 0;
    int           out_cnt = 0;
    int           cyc_cnt = 0;
    int           err_mark;
    logic         mon_en = 1'b0;
    logic         ready_low_seen = 1'b0;

    txdata_queue #(.BLOCK_LEN(BLOCK_LEN)) dut_i (
        .i_clk      (i_clk),
        .i_reset    (i_reset),
        .i_ant_data (i_ant_data),
        .i_rx_vld   (i_rx_vld),
        .i_ant0_idx (i_ant0_idx),
        .i_cell_idx (i_cell_idx),
        .i_slot_idx (i_slot_idx),
        .i_symb_idx (i_symb_idx),
        .o_tx_data  (o_tx_data),
        .o_tx_vld   (o_tx_vld),
        .o_tx_sop   (o_tx_sop),
        .o_tx_eop   (o_tx_eop),
        .o_prb_idx  (o_prb_idx),
        .o_pkg_info (o_pkg_info),
        .o_cell_idx (o_cell_idx),
        .o_slot_idx (o_slot_idx),
        .o_symb_idx (o_symb_idx),
        .o_tready   (o_tready)
    );

    initial i_clk = 1'b0;
    always #2 i_clk = ~i_clk;

    // ----------------------------------------------------------------------
    // Cycle limit and monitor enable
    // ----------------------------------------------------------------------
    always @(posedge i_clk) begin
        cyc_cnt <= cyc_cnt + 1;
        mon_en  <= !i_reset;
        if (cyc_cnt >= TIMEOUT) begin
            $display("ERROR: timeout, output stream not finished after %0d cycles", cyc_cnt);
            $display("ERRORS FOUND");
            $finish;
        end
    end

    task automatic check_value(input string what, input logic [127:0] got,
                               input logic [127:0] exp);
        chk_cnt++;
        if (got !== exp) begin
            $display("FAIL %0t: %s is %0h, expected %0h", $time, what, got, exp);
            err_cnt++;
        end
    endtask

    // Lane k of group g carries antenna ant0 + 2k + g, wrapped to 4 bits
    function automatic logic [7:0] pkg_byte(input logic grp, input int lane);
        logic [3:0] ant;
        ant = 4'(int'(i_ant0_idx) + 2 * lane + int'(grp));
        return {3'b000, grp, ant};
    endfunction

    task automatic report_test(input string name, input int err_before);
        if (err_cnt == err_before) begin
            test_pass++;
            $display("test %s: passed", name);
        end else begin
            test_fail++;
            $display("test %s: failed with %0d mismatches", name, err_cnt - err_before);
        end
    endtask

    // One block of BLOCK_LEN valid samples with random idle gaps
    task automatic send_block();
        logic [140:0]     even_q [$];
        logic [140:0]     odd_q [$];
        logic [3:0][31:0] even_w;
        logic [3:0][31:0] odd_w;
        logic [11:0]      meta;
        int               r;
        int               n;
        n = 0;
        while (!o_tready) begin
            @(negedge i_clk);
        end
        while (n < BLOCK_LEN) begin
            r = $random(seed);
            if (r[1:0] == 2'b00) begin
                i_rx_vld = 1'b0;
            end else begin
                for (int a = 0; a < 8; a++) begin
                    i_ant_data[a] = $random(seed);
                end
                r = $random(seed);
                meta = r[11:0];
                i_cell_idx = meta[11];
                i_slot_idx = meta[10:4];
                i_symb_idx = meta[3:0];
                i_rx_vld   = 1'b1;
                for (int k = 0; k < 4; k++) begin
                    even_w[k] = i_ant_data[2 * k];
                    odd_w[k]  = i_ant_data[2 * k + 1];
                end
                even_q.push_back({1'b0, meta, even_w});
                odd_q.push_back({1'b1, meta, odd_w});
                n++;
            end
            @(negedge i_clk);
        end
        i_rx_vld = 1'b0;
        // Whole even group first, then the whole odd group
        foreach (even_q[i]) begin
            exp_q.push_back(even_q[i]);
        end
        foreach (odd_q[i]) begin
            exp_q.push_back(odd_q[i]);
        end
    endtask

    // ----------------------------------------------------------------------
    // Output monitor
    // ----------------------------------------------------------------------
    always @(negedge i_clk) begin
        if (mon_en) begin
            if (!o_tready) begin
                ready_low_seen = 1'b1;
            end
            check_value("o_tx_sop", 128'(o_tx_sop),
                        128'(o_tx_vld && (out_cnt % PKT_LEN == 0)));
            check_value("o_tx_eop", 128'(o_tx_eop),
                        128'(o_tx_vld && (out_cnt % RE_PER_PRB == RE_PER_PRB - 1)));
            if (o_tx_vld) begin
                check_value("o_prb_idx", 128'(o_prb_idx),
                            128'((out_cnt % BLOCK_LEN) / RE_PER_PRB));
                if (exp_q.size() == 0) begin
                    $display("ERROR: output sample %0d at %0t was not expected", out_cnt, $time);
                    err_cnt++;
                end else begin
                    cur_exp = exp_q.pop_front();
                    check_value("o_tx_data", o_tx_data, cur_exp[127:0]);
                    check_value("o_cell_idx", 128'(o_cell_idx), 128'(cur_exp[139]));
                    check_value("o_slot_idx", 128'(o_slot_idx), 128'(cur_exp[138:132]));
                    check_value("o_symb_idx", 128'(o_symb_idx), 128'(cur_exp[131:128]));
                    for (int k = 0; k < 4; k++) begin
                        check_value("o_pkg_info", 128'(o_pkg_info[k]),
                                    128'(pkg_byte(cur_exp[140], k)));
                    end
                end
                out_cnt++;
            end
        end
    end

    initial begin
        i_reset    = 1'b1;
        i_rx_vld   = 1'b0;
        i_ant_data = '0;
        i_cell_idx = 1'b0;
        i_slot_idx = '0;
        i_symb_idx = '0;
        i_ant0_idx = 4'($random(seed));
        repeat (RESET_CYC) @(negedge i_clk);
        i_reset = 1'b0;
        @(negedge i_clk);

        err_mark = err_cnt;
        check_value("o_tready after reset", 128'(o_tready), 128'(1'b1));
        check_value("o_tx_vld after reset", 128'(o_tx_vld), 128'(1'b0));
        report_test("reset state", err_mark);

        // Blocks go out back to back whenever a slot is free
        err_mark = err_cnt;
        for (int b = 0; b < NUM_BLK; b++) begin
            send_block();
        end
        while (out_cnt < NUM_BLK * 2 * BLOCK_LEN) begin
            @(negedge i_clk);
        end
        // Idle tail to catch stray output samples
        repeat (8) @(negedge i_clk);
        report_test("block order, metadata, package info and framing", err_mark);

        err_mark = err_cnt;
        check_value("o_tready seen low", 128'(ready_low_seen), 128'(1'b1));
        report_test("ready flag", err_mark);

        err_mark = err_cnt;
        check_value("expected samples left", 128'(exp_q.size()), 128'(0));
        check_value("output sample count", 128'(out_cnt), 128'(NUM_BLK * 2 * BLOCK_LEN));
        check_value("o_tready at end", 128'(o_tready), 128'(1'b1));
        report_test("drain", err_mark);

        $display("summary: %0d tests passed, %0d tests failed, %0d checks, %0d mismatches",
                 test_pass, test_fail, chk_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: txdata_queue.f
hdl/txq_pkg.sv
hdl/txq_rd_if.sv
hdl/txq_write_ctrl.sv
hdl/txq_group_ram.sv
hdl/txq_read_seq.sv
hdl/txq_re_framer.sv
hdl/txq_out_stage.sv
hdl/txdata_queue.sv
bench/txdata_queue_tb.sv

// File: Makefile
TOP := txdata_queue_tb

.PHONY: help test clean

help:
	@echo "make test   build with Verilator and run the testbench"
	@echo "make clean  remove the Verilator build directory"

test:
	verilator --binary --timing --assert --top-module $(TOP) -Mdir obj_dir -f txdata_queue.f
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "NO ERRORS"

clean:
	rm -rf obj_dir
